//--- run.sh
#!/bin/sh
# Build the shift unit testbench with Verilator and run it.
# Exit status is 0 only when the run reports success.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f shift_unit.f \
  --top-module shift_unit_tb \
  -o shift_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/shift_unit_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

//--- shift_unit.f
src/shift_pkg.sv
src/shift_operand_align.sv
src/shift_right_core.sv
src/shift_result_align.sv
src/shift_flags.sv
src/shift_unit.sv
verif/tb_clock.sv
verif/shift_unit_tb.sv

//--- src/shift_flags.sv
////////////////////////////////////////
// Flag logic for SHL, SHR and SAR. AF is always 0,
// OF is defined for every count.
////////////////////////////////////////

module shift_flags (
  input  shift_pkg::shift_op_t op,
  input  shift_pkg::op_size_t  size,
  input  shift_pkg::word_t     result,
  input  logic                 carry,
  input  logic                 msb,
  input  logic                 count_zero,
  output shift_pkg::flags_t    flags,
  output logic                 flag_update
);

  import shift_pkg::*;

  logic top_bit;      // Result MSB at operand size.
  logic is_zero;      // Size-wide result is zero.
  logic parity_even;  // Low byte has even ones.
  logic of_bit;

  ////////////////////////////////////////
  // Size dependent result checks
  ////////////////////////////////////////
  always_comb begin
    case (size)
      SIZE_8: begin
        top_bit = result[7];
        is_zero = (result[7:0] == 8'h0);
      end
      SIZE_16: begin
        top_bit = result[15];
        is_zero = (result[15:0] == 16'h0);
      end
      default: begin
        top_bit = result[31];
        is_zero = (result == '0);
      end
    endcase
  end

  assign parity_even = ~^result[7:0];  // PF looks at the low byte only.

  // OF rule per operation.
  always_comb begin
    case (op)
      OP_SHL:  of_bit = top_bit ^ carry;
      OP_SAR:  of_bit = 1'b0;
      default: of_bit = msb;             // SHR, original sign bit.
    endcase
  end

  ////////////////////////////////////////
  // Flag vector
  ////////////////////////////////////////
  always_comb begin
    flags          = '0;
    flags[FLAG_CF] = carry;
    flags[FLAG_PF] = parity_even;
    flags[FLAG_AF] = 1'b0;
    flags[FLAG_ZF] = is_zero;
    flags[FLAG_SF] = top_bit;
    flags[FLAG_OF] = of_bit;
  end

  // Count of zero leaves the flags alone.
  assign flag_update = ~count_zero;

endmodule

//--- src/shift_operand_align.sv
////////////////////////////////////////
// Prepares the operand for the shared right shifter.
// SHL leaves the word bit-reversed with its MSB at bit 0.
////////////////////////////////////////

module shift_operand_align (
  input  shift_pkg::shift_op_t op,
  input  shift_pkg::op_size_t  size,
  input  shift_pkg::word_t     operand,
  output shift_pkg::word_t     aligned,
  output logic                 fill,
  output logic                 msb
);

  import shift_pkg::*;

  word_t zext;    // Zero-extended operand.
  word_t sext;    // Sign-extended operand.
  word_t upper;   // Operand moved up to bit 31.

  ////////////////////////////////////////
  // Size dependent views of the operand
  ////////////////////////////////////////
  always_comb begin
    case (size)
      SIZE_8: begin
        msb   = operand[7];
        zext  = {24'h0, operand[7:0]};
        sext  = {{24{operand[7]}}, operand[7:0]};
        upper = {operand[7:0], 24'h0};
      end
      SIZE_16: begin
        msb   = operand[15];
        zext  = {16'h0, operand[15:0]};
        sext  = {{16{operand[15]}}, operand[15:0]};
        upper = {operand[15:0], 16'h0};
      end
      default: begin  // 32 bits, reserved code too.
        msb   = operand[31];
        zext  = operand;
        sext  = operand;
        upper = operand;
      end
    endcase
  end

  ////////////////////////////////////////
  // Pick the word and fill per operation
  ////////////////////////////////////////
  always_comb begin
    case (op)
      OP_SHL: begin
        aligned = bit_reverse(upper);  // Left shift becomes right shift.
        fill    = 1'b0;
      end
      OP_SAR: begin
        aligned = sext;
        fill    = msb;                 // Sign fill.
      end
      default: begin                   // SHR and reserved.
        aligned = zext;
        fill    = 1'b0;
      end
    endcase
  end

endmodule

//--- src/shift_pkg.sv
////////////////////////////////////////
// Shared types for the shift unit. Data path is fixed to 32 bits.
// Reserved size code is treated as 32, reserved op code as SHR.
////////////////////////////////////////

package shift_pkg;

  typedef logic [31:0] word_t;    // Data word.
  typedef logic [4:0]  count_t;   // Count, already masked modulo 32.
  typedef logic [5:0]  flags_t;   // Arithmetic flag vector.

  // Operand size.
  typedef enum logic [1:0] {
    SIZE_8    = 2'd0,
    SIZE_16   = 2'd1,
    SIZE_32   = 2'd2,
    SIZE_RSVD = 2'd3
  } op_size_t;

  // Shift operation.
  typedef enum logic [1:0] {
    OP_SHL  = 2'd0,
    OP_SHR  = 2'd1,
    OP_SAR  = 2'd2,
    OP_RSVD = 2'd3
  } shift_op_t;

  // Bit positions inside flags_t.
  localparam int unsigned FLAG_CF = 0;
  localparam int unsigned FLAG_PF = 1;
  localparam int unsigned FLAG_AF = 2;
  localparam int unsigned FLAG_ZF = 3;
  localparam int unsigned FLAG_SF = 4;
  localparam int unsigned FLAG_OF = 5;

  // Mirror a word end for end.
  function automatic word_t bit_reverse(input word_t w);
    word_t r;
    for (int i = 0; i < $bits(word_t); i++) begin
      r[i] = w[$bits(word_t) - 1 - i];
    end
    return r;
  endfunction

  // Ones over the low bits that belong to the operand size.
  function automatic word_t size_mask(input op_size_t size);
    case (size)
      SIZE_8:  return 32'h0000_00ff;
      SIZE_16: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

endpackage

//--- src/shift_result_align.sv
////////////////////////////////////////
// Turns the shifter output into the final result,
// zero-extended from the operand size.
////////////////////////////////////////

module shift_result_align (
  input  shift_pkg::shift_op_t           op,
  input  shift_pkg::op_size_t            size,
  input  logic [$bits(shift_pkg::word_t):0] shifted,
  output shift_pkg::word_t               result
);

  import shift_pkg::*;

  word_t body;      // Shifter output without carry.
  word_t restored;  // Undone reversal for SHL.
  word_t lowered;   // SHL result back at bit 0.

  assign body     = shifted[$bits(word_t):1];
  assign restored = bit_reverse(body);

  // Bring the SHL result back down by 32 minus size.
  always_comb begin
    case (size)
      SIZE_8:  lowered = restored >> 24;
      SIZE_16: lowered = restored >> 16;
      default: lowered = restored;
    endcase
  end

  // Mask drops the SAR sign fill above the operand.
  always_comb begin
    if (op == OP_SHL) begin
      result = lowered & size_mask(size);
    end else begin
      result = body & size_mask(size);
    end
  end

endmodule

//--- src/shift_right_core.sv
////////////////////////////////////////
// Logarithmic right shifter, WIDTH a power of two.
// Output bit 0 holds the last bit shifted out.
////////////////////////////////////////

module shift_right_core #(
  parameter int WIDTH = 32
) (
  input  shift_pkg::count_t amt,
  input  logic              fill,
  input  shift_pkg::word_t  data,
  output logic [WIDTH:0]    shifted,
  output logic              count_zero
);

  localparam int AMT_W = $clog2(WIDTH);  // Number of mux rows.

  // Row 0 is the input, row AMT_W the result.
  logic [WIDTH:0] row [0:AMT_W];

  ////////////////////////////////////////
  // Input row with the carry slot below
  ////////////////////////////////////////
  // Zero below the data; it only shows at a zero amount.
  assign row[0] = {data[WIDTH-1:0], 1'b0};

  ////////////////////////////////////////
  // Mux rows, largest step first
  ////////////////////////////////////////
  for (genvar j = 1; j <= AMT_W; j++) begin : g_row
    localparam int STEP = WIDTH >> j;  // Half the previous step.

    always_comb begin
      if (amt[AMT_W-j]) begin
        // Move down by STEP, fill enters at the top.
        row[j] = {{STEP{fill}}, row[j-1][WIDTH:STEP]};
      end else begin
        row[j] = row[j-1];
      end
    end
  end

  assign shifted = row[AMT_W];

  // Zero amount, the flags stay untouched then.
  assign count_zero = (amt[AMT_W-1:0] == '0);

endmodule

//--- src/shift_unit.sv
////////////////////////////////////////
// Two stage shift unit, result 2 cycles after op_valid.
// No back-pressure; each result shows for one cycle only.
////////////////////////////////////////

module shift_unit #(
  parameter int WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 op_valid,
  input  shift_pkg::shift_op_t op,
  input  shift_pkg::op_size_t  size,
  input  shift_pkg::word_t     operand,
  input  logic [7:0]           count_in,
  output logic                 res_valid,
  output shift_pkg::word_t     result,
  output shift_pkg::flags_t    flags,
  output logic                 flags_we
);

  import shift_pkg::*;

  // Stage 1.
  logic      s1_valid;
  shift_op_t s1_op;
  op_size_t  s1_size;
  word_t     s1_operand;
  count_t    s1_count;

  // Datapath.
  word_t          aligned;
  logic           fill;
  logic           msb;
  logic [WIDTH:0] shifted;
  logic           count_zero;
  word_t          dp_result;
  flags_t         dp_flags;
  logic           dp_update;

  // Stage 2.
  logic s2_update;

  ////////////////////////////////////////
  // Stage 1 registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      s1_op      <= op;
      s1_size    <= size;
      s1_operand <= operand;
      s1_count   <= count_in[4:0];  // Modulo 32.
    end
  end

  ////////////////////////////////////////
  // Shift datapath
  ////////////////////////////////////////
  shift_operand_align u_align_in (
    .op      (s1_op),
    .size    (s1_size),
    .operand (s1_operand),
    .aligned (aligned),
    .fill    (fill),
    .msb     (msb)
  );

  shift_right_core #(.WIDTH(WIDTH)) u_core (
    .amt        (s1_count),
    .fill       (fill),
    .data       (aligned),
    .shifted    (shifted),
    .count_zero (count_zero)
  );

  shift_result_align u_align_out (
    .op      (s1_op),
    .size    (s1_size),
    .shifted (shifted),
    .result  (dp_result)
  );

  shift_flags u_flags (
    .op          (s1_op),
    .size        (s1_size),
    .result      (dp_result),
    .carry       (shifted[0]),  // Last bit out.
    .msb         (msb),
    .count_zero  (count_zero),
    .flags       (dp_flags),
    .flag_update (dp_update)
  );

  ////////////////////////////////////////
  // Stage 2 registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      result    <= '0;
      flags     <= '0;
      s2_update <= 1'b0;
    end else begin
      res_valid <= s1_valid;
      if (s1_valid) begin  // Hold last result between ops.
        result    <= dp_result;
        flags     <= dp_flags;
        s2_update <= dp_update;
      end
    end
  end

  assign flags_we = res_valid & s2_update;  // Only with a live result.

endmodule

//--- verif/shift_unit_tb.sv
////////////////////////////////////////
// Random and directed testbench for shift_unit.
// Flags are compared only when a flag write is expected.
////////////////////////////////////////

module shift_unit_tb;

  import shift_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_DIRECTED = 144;  // 3 ops, 3 sizes, 2 operands, 8 counts.
  localparam int N_FLAG     = 108;  // 3 ops, 3 sizes, 6 patterns, 2 counts.
  localparam int N_B2B      = 256;
  localparam int N_GAP      = 128;
  localparam int MAX_GAP    = 3;
  localparam int TOTAL_OPS  = 1 + N_DIRECTED + N_FLAG + N_B2B + N_GAP;
  localparam int WATCHDOG   = (TOTAL_OPS + N_GAP * MAX_GAP) * CLK_PERIOD + 400;

  logic       clk;
  logic       arst_n;
  logic       op_valid;
  shift_op_t  op;
  op_size_t   size;
  word_t      operand;
  logic [7:0] count_in;
  logic       res_valid;
  word_t      result;
  flags_t     flags;
  logic       flags_we;

  logic [31:0] lfsr;
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;

  // Expected values in issue order.
  logic [31:0] q_res [$];
  logic [5:0]  q_flg [$];
  logic        q_we  [$];
  int          q_cyc [$];

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clock (.clk(clk), .arst_n(arst_n));

  shift_unit #(.WIDTH(32)) dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .op_valid (op_valid),
    .op       (op),
    .size     (size),
    .operand  (operand),
    .count_in (count_in),
    .res_valid(res_valid),
    .result   (result),
    .flags    (flags),
    .flags_we (flags_we)
  );

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1.
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // x86 shift rules on a size-wide operand with the count modulo 32.
  function automatic void expected_shift(input logic [1:0] o, input logic [1:0] s,
                                         input logic [31:0] d, input logic [7:0] c,
                                         output logic [31:0] res, output logic [5:0] flg,
                                         output logic we);
    int          bits;
    int          sh;
    logic [4:0]  cnt5;
    logic [31:0] mask;
    logic [31:0] tmp32;
    logic [63:0] v;
    logic [63:0] w;
    logic        cf;
    logic        top;
    logic        op_msb;
    cnt5  = c[4:0];
    sh    = int'(cnt5);
    bits  = (s == 2'd0) ? 8 : (s == 2'd1) ? 16 : 32;  // Reserved code is 32.
    mask  = (bits == 32) ? 32'hFFFF_FFFF : ((32'd1 << bits) - 32'd1);
    tmp32 = d >> (bits - 1);
    op_msb = tmp32[0];
    v     = {32'h0, d & mask};
    if (o == 2'd0) begin
      w  = v << sh;
      v  = w >> bits;  // Last bit pushed past the top.
      cf = (sh != 0) ? v[0] : 1'b0;
    end else begin
      if (o == 2'd2 && op_msb) begin
        v = v | {32'hFFFF_FFFF, ~mask};  // Sign extension.
      end
      w  = v >> sh;
      v  = v >> ((sh != 0) ? sh - 1 : 0);
      cf = (sh != 0) ? v[0] : 1'b0;
    end
    res   = w[31:0] & mask;
    tmp32 = res >> (bits - 1);
    top   = tmp32[0];
    flg          = '0;
    flg[FLAG_CF] = cf;
    flg[FLAG_PF] = ~^res[7:0];
    flg[FLAG_ZF] = (res == 32'h0);
    flg[FLAG_SF] = top;
    if (o == 2'd0) begin
      flg[FLAG_OF] = top ^ cf;
    end else if (o != 2'd2) begin
      flg[FLAG_OF] = op_msb;  // SHR and reserved.
    end
    we = (sh != 0);
  endfunction

  ////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s expected 0x%0h got 0x%0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_output();
    logic [31:0] e_res;
    logic [5:0]  e_flg;
    logic        e_we;
    int          e_cyc;
    assert (q_res.size() != 0) else begin
      $display("FAIL: res_valid pulsed with no operation in flight");
      errors++;
    end
    if (q_res.size() != 0) begin
      e_res = q_res.pop_front();
      e_flg = q_flg.pop_front();
      e_we  = q_we.pop_front();
      e_cyc = q_cyc.pop_front();
      assert (cyc == e_cyc + 2) else begin
        $display("FAIL: result came %0d cycles after issue instead of 2", cyc - e_cyc);
        errors++;
      end
      check_value("result", e_res, result);
      check_value("flags_we", 32'(e_we), 32'(flags_we));
      if (e_we) check_value("flags", 32'(e_flg), 32'(flags));
    end
  endtask

  // Outputs sampled on the falling edge.
  always @(negedge clk) begin
    logic [31:0] e_res;
    logic [5:0]  e_flg;
    logic        e_we;
    cyc++;
    if (res_valid) begin
      check_output();
    end else begin
      assert (flags_we == 1'b0) else begin
        $display("FAIL flags_we expected 0x0 got 0x%0h", flags_we);
        errors++;
      end
    end
    if (arst_n && op_valid) begin
      expected_shift(op, size, operand, count_in, e_res, e_flg, e_we);
      q_res.push_back(e_res);
      q_flg.push_back(e_flg);
      q_we.push_back(e_we);
      q_cyc.push_back(cyc);
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////
  task automatic issue_op(input logic [1:0] o, input logic [1:0] s,
                          input logic [31:0] d, input logic [7:0] c);
    @(posedge clk);
    op_valid <= 1'b1;
    op       <= shift_op_t'(o);
    size     <= op_size_t'(s);
    operand  <= d;
    count_in <= c;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      op_valid <= 1'b0;
    end
  endtask

  task automatic drain_pipeline();
    idle_cycles(1);
    while (q_res.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);  // Catch stray strobes.
  endtask

  task automatic report_test(input string name, input int err_start);
    drain_pipeline();
    if (errors == err_start) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err_start);
  endtask

  task automatic random_ops(input int n, input bit gaps);
    for (int i = 0; i < n; i++) begin
      issue_op(2'(take_bits(2)), 2'(take_bits(2)), take_bits(32), 8'(take_bits(8)));
      if (gaps) idle_cycles(int'(take_bits(2)));
    end
  endtask

  task automatic directed_edges();
    int          bits;
    int          counts [8];
    logic [31:0] pats [2];
    for (int o = 0; o < 3; o++) begin
      for (int s = 0; s < 3; s++) begin
        bits    = 8 << s;
        counts  = '{0, 1, bits, bits + 1, 31, 32, 37, 255};
        pats[0] = 32'hC3A5_9681;
        pats[1] = take_bits(32);
        for (int p = 0; p < 2; p++) begin
          for (int k = 0; k < 8; k++) begin
            issue_op(2'(o), 2'(s), pats[p], 8'(counts[k]));
          end
        end
      end
    end
  endtask

  task automatic flag_patterns();
    logic [31:0] pats [6];
    pats = '{32'h0000_0000, 32'h8080_8080, 32'hFFFF_FFFF,
             32'h0000_0003, 32'h4040_4040, 32'h7F7F_7F7F};
    for (int o = 0; o < 3; o++) begin
      for (int s = 0; s < 3; s++) begin
        for (int p = 0; p < 6; p++) begin
          issue_op(2'(o), 2'(s), pats[p], 8'd1);
          issue_op(2'(o), 2'(s), pats[p], 8'd4);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence and watchdog
  ////////////////////////////////////////
  initial begin
    int err_start;
    op_valid = 1'b0;
    op       = OP_SHL;
    size     = SIZE_8;
    operand  = '0;
    count_in = '0;
    lfsr     = 32'd66164;
    wait (arst_n === 1'b1);
    err_start = errors;
    @(negedge clk);
    check_value("result", 32'h0, result);  // Reset values.
    check_value("flags", 32'h0, 32'(flags));
    idle_cycles(3);  // No strobe before the first op.
    issue_op(2'd1, 2'd2, 32'h8000_0001, 8'd1);
    report_test("reset", err_start);
    err_start = errors;
    directed_edges();
    report_test("directed", err_start);
    err_start = errors;
    random_ops(N_B2B, 1'b0);
    report_test("back_to_back", err_start);
    err_start = errors;
    random_ops(N_GAP, 1'b1);
    report_test("gaps", err_start);
    err_start = errors;
    flag_patterns();
    report_test("flags", err_start);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("FAIL: watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
////////////////////////////////////////
// Testbench clock and reset. Reset is released
// on a rising edge after RESET_CYCLES cycles.
////////////////////////////////////////

module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;  // Held low from time zero.
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule
